//--- pss_tests.txt
# name mode requested_nid embedded_seq(3 = none) amp_re amp_im exp_pulses exp_nid
# mode 0 search, 1 find, 2 pause, 3 acts as pause
search_seq0   0 0 0  2000  1000 1 0
search_seq1   0 0 1 -1500  2500 1 1
search_seq2   0 0 2  3000  -700 1 2
find_match1   1 1 1  1800  1800 1 1
find_other    1 2 0  1800  1800 0 0
find_match2   1 2 2 -2000  -900 1 2
pause_seq0    2 0 0  2000  1000 0 0
mode3_seq1    3 0 1  2000  1000 0 0
low_amp       0 0 0   100    60 0 0
background    0 0 3     0     0 0 0

//--- pss_detector.f
pss_pkg.sv
pss_corr_if.sv
pss_correlator_bank.sv
window_energy.sv
nid_decision.sv
pss_detector.sv
pss_checker.sv
pss_detector_properties.sv
tb_pss_detector.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

obj_dir/Vtb_pss_detector: pss_detector.f *.sv
	verilator --binary --timing --assert -Wall -Wno-fatal -f pss_detector.f \
		--top-module tb_pss_detector -Mdir obj_dir

test: obj_dir/Vtb_pss_detector
	./obj_dir/Vtb_pss_detector > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Something failed" sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_pss_detector.sv
`timescale 1ns/1ns

module tb_pss_detector
    import pss_pkg::*;
;

    logic                 clk_i;
    logic                 reset_int_n;
    logic [SAMPLE_DW-1:0] sample_i;
    logic                 sample_valid_i;
    logic [1:0]           mode_i;
    logic [1:0]           requested_nid_i;
    logic [1:0]           nid_o;
    logic                 nid_valid_o;
    logic                 loaded = 1'b0;

    string names [$];
    int    t_mode [$];
    int    t_req [$];
    int    t_seq [$];
    int    t_are [$];
    int    t_aim [$];
    int    t_cnt [$];
    int    t_nid [$];

    pss_detector uut (.*);

    pss_checker chk (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // random idle cycles, then one valid sample
    task automatic send_sample(input int re, input int im);
        while ($urandom_range(0, 3) == 0) begin
            sample_valid_i = 1'b0;
            @(negedge clk_i);
        end
        sample_i       = {16'(im), 16'(re)};
        sample_valid_i = 1'b1;
        @(negedge clk_i);
        sample_valid_i = 1'b0;
    endtask

    task automatic send_noise(input int count);
        for (int i = 0; i < count; i++) begin
            send_sample(int'($urandom_range(0, 126)) - 63, int'($urandom_range(0, 126)) - 63);
        end
    endtask

    // taps 1 to 15 of a strong sequence while the window is still filling
    task automatic check_after_reset(input int t);
        int seq;
        seq = (t_seq[t] == 3) ? 0 : t_seq[t];
        chk.begin_test("after_reset", 0, 0);
        for (int i = 1; i < PSS_LEN; i++) begin
            if (PSS_SEQ[seq][i]) begin
                send_sample(t_are[t], t_aim[t]);
            end else begin
                send_sample(-t_are[t], -t_aim[t]);
            end
        end
        repeat (4) @(negedge clk_i);
        chk.end_test();
    endtask

    task automatic run_test(input int t);
        mode_i          = 2'(t_mode[t]);
        requested_nid_i = 2'(t_req[t]);
        chk.begin_test(names[t], t_cnt[t], t_nid[t]);
        send_noise(16);
        for (int i = 0; i < PSS_LEN; i++) begin
            if (t_seq[t] == 3) begin
                send_noise(1);
            end else if (PSS_SEQ[t_seq[t]][i]) begin
                send_sample(t_are[t], t_aim[t]);
            end else begin
                send_sample(-t_are[t], -t_aim[t]);
            end
        end
        send_noise(24);
        repeat (4) @(negedge clk_i);
        chk.end_test();
    endtask

    task automatic read_tests(input int fd);
        string line;
        string nm;
        int    md;
        int    rq;
        int    sq;
        int    ar;
        int    ai;
        int    ec;
        int    en;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%s %d %d %d %d %d %d %d",
                            nm, md, rq, sq, ar, ai, ec, en) == 8) begin
                    names.push_back(nm);
                    t_mode.push_back(md);
                    t_req.push_back(rq);
                    t_seq.push_back(sq);
                    t_are.push_back(ar);
                    t_aim.push_back(ai);
                    t_cnt.push_back(ec);
                    t_nid.push_back(en);
                end
            end
        end
    endtask

    initial begin
        int fd;
        void'($urandom(32'hc4af1ef1));
        reset_int_n     = 1'b0;
        sample_i        = '0;
        sample_valid_i  = 1'b0;
        mode_i          = MODE_SEARCH;
        requested_nid_i = 2'd0;
        fd = $fopen("pss_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file pss_tests.txt");
            $display("Something failed");
            $finish;
        end else begin
            read_tests(fd);
            $fclose(fd);
            loaded = 1'b1;
            repeat (5) @(negedge clk_i);
            reset_int_n = 1'b1;
            if (names.size() > 0) begin
                check_after_reset(0);
            end
            for (int t = 0; t < names.size(); t++) begin
                run_test(t);
            end
            repeat (5) @(negedge clk_i);
            chk.report();
            if (chk.tests_failed == 0 && chk.window_errors == 0 &&
                    uut.u_decision.u_props.assert_failures == 0 && names.size() > 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

    // watchdog, 80 samples per test at two cycles each
    initial begin
        wait (loaded);
        #(names.size() * 80 * 2 * 100 + 2000);
        $display("timeout: the tests did not finish in the expected time");
        $display("Something failed");
        $finish;
    end

endmodule

//--- pss_detector_properties.sv
`timescale 1ns/1ns

module pss_detector_properties
    import pss_pkg::*;
(
    input logic       clk_i,
    input logic       reset_int_n,
    input logic       metric_valid,
    input logic [1:0] mode_i,
    input logic [1:0] nid_o,
    input logic       nid_valid_o
);

    int assert_failures = 0;

    // a pulse always comes from a valid metric set one cycle before
    a_pulse_after_metric: assert property (@(posedge clk_i) disable iff (!reset_int_n)
        nid_valid_o |-> $past(metric_valid))
        else begin
            $error("nid_valid_o without metric_valid in the cycle before");
            assert_failures++;
        end

    a_no_pulse_in_pause: assert property (@(posedge clk_i) disable iff (!reset_int_n)
        nid_valid_o |-> ($past(mode_i) == MODE_SEARCH || $past(mode_i) == MODE_FIND))
        else begin
            $error("nid_valid_o rose while the mode was pause");
            assert_failures++;
        end

    a_nid_range: assert property (@(posedge clk_i) disable iff (!reset_int_n)
        nid_o != 2'd3)
        else begin
            $error("nid_o took the value 3");
            assert_failures++;
        end

endmodule

bind nid_decision pss_detector_properties u_props (
    .clk_i        (clk_i),
    .reset_int_n  (reset_int_n),
    .metric_valid (corr.metric_valid),
    .mode_i       (mode_i),
    .nid_o        (nid_o),
    .nid_valid_o  (nid_valid_o)
);

//--- pss_checker.sv
`timescale 1ns/1ns

module pss_checker
    import pss_pkg::*;
(
    input logic                 clk_i,
    input logic                 reset_int_n,
    input logic [SAMPLE_DW-1:0] sample_i,
    input logic                 sample_valid_i,
    input logic [1:0]           mode_i,
    input logic [1:0]           requested_nid_i,
    input logic [1:0]           nid_o,
    input logic                 nid_valid_o
);

    logic [SAMPLE_DW-1:0] win [$];
    logic [2:0]           pipe_v;
    logic [1:0]           pipe_n [3];
    logic [1:0]           held_n;
    logic                 new_v;
    logic [1:0]           new_n;
    string                test_name = "reset";
    int                   exp_count;
    int                   exp_nid;
    int                   pulses;
    int                   last_nid;
    int                   test_errors;
    int                   tests_run;
    int                   tests_failed;
    int                   window_errors;

    function automatic int iabs(input int v);
        return (v < 0) ? -v : v;
    endfunction

    // reference rule over the current 16-sample window
    task automatic model_decision(output logic v, output logic [1:0] n);
        int re;
        int im;
        int energy;
        int metric;
        int peaks;
        int idx;
        int re_sum [3];
        int im_sum [3];
        energy = 0;
        peaks  = 0;
        idx    = 0;
        for (int k = 0; k < 3; k++) begin
            re_sum[k] = 0;
            im_sum[k] = 0;
        end
        for (int i = 0; i < PSS_LEN; i++) begin
            re = int'($signed(win[i][15:0]));
            im = int'($signed(win[i][31:16]));
            energy += iabs(re) + iabs(im);
            for (int k = 0; k < 3; k++) begin
                re_sum[k] += PSS_SEQ[k][i] ? re : -re;
                im_sum[k] += PSS_SEQ[k][i] ? im : -im;
            end
        end
        for (int k = 0; k < 3; k++) begin
            metric = iabs(re_sum[k]) + iabs(im_sum[k]);
            if (energy >= int'(NOISE_LIMIT) && 8 * metric >= 7 * energy) begin
                peaks++;
                idx = k;
            end
        end
        n = 2'(idx);
        v = (peaks == 1) && ((mode_i == MODE_SEARCH) ||
                             (mode_i == MODE_FIND && 2'(idx) == requested_nid_i));
    endtask

    always @(posedge clk_i) begin
        if (!reset_int_n) begin
            win.delete();
            pipe_v = '0;
            held_n = 2'd0;
        end else begin
            // nid_o keeps the last reported id between pulses
            if (pipe_v[2]) begin
                held_n = pipe_n[2];
            end
            if (pipe_v[2] !== nid_valid_o || nid_o !== held_n) begin
                $display("Fail %s: window expected pulse %0d nid %0d, actual pulse %0d nid %0d",
                         test_name, pipe_v[2], held_n, nid_valid_o, nid_o);
                test_errors++;
                window_errors++;
            end
            if (nid_valid_o) begin
                pulses++;
                last_nid = nid_o;
            end
            new_v = 1'b0;
            new_n = 2'd0;
            if (sample_valid_i) begin
                win.push_back(sample_i);
                if (win.size() > PSS_LEN) begin
                    void'(win.pop_front());
                end
                if (win.size() == PSS_LEN) begin
                    model_decision(new_v, new_n);
                end
            end
            // the pulse is due three edges later
            pipe_v    = {pipe_v[1:0], new_v};
            pipe_n[2] = pipe_n[1];
            pipe_n[1] = pipe_n[0];
            pipe_n[0] = new_n;
        end
    end

    task automatic begin_test(input string name, input int count, input int nid);
        test_name   = name;
        exp_count   = count;
        exp_nid     = nid;
        pulses      = 0;
        last_nid    = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (pulses == exp_count && (exp_count == 0 || last_nid == exp_nid) && test_errors == 0) begin
            $display("pass %s", test_name);
        end else begin
            $display("Fail %s: expected %0d pulses nid %0d, actual %0d pulses nid %0d",
                     test_name, exp_count, exp_nid, pulses, last_nid);
            tests_failed++;
        end
    endtask

    task automatic report();
        $display("tests run %0d, passed %0d, failed %0d, window mismatches %0d",
                 tests_run, tests_run - tests_failed, tests_failed, window_errors);
    endtask

endmodule

//--- pss_detector.sv
`timescale 1ns/1ns

module pss_detector
    import pss_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 reset_int_n,
    input  logic [SAMPLE_DW-1:0] sample_i,
    input  logic                 sample_valid_i,
    input  logic [1:0]           mode_i,
    input  logic [1:0]           requested_nid_i,
    output logic [1:0]           nid_o,
    output logic                 nid_valid_o
);

    sample_t              sample_word;
    logic [METRIC_DW-1:0] energy;
    logic                 energy_valid;

    pss_corr_if corr ();

    assign sample_word.raw = sample_i;

    // correlators and energy window see the same samples
    pss_correlator_bank u_corr_bank (
        .clk_i          (clk_i),
        .reset_int_n    (reset_int_n),
        .sample_i       (sample_word),
        .sample_valid_i (sample_valid_i),
        .corr           (corr.bank)
    );

    window_energy u_energy (
        .clk_i          (clk_i),
        .reset_int_n    (reset_int_n),
        .sample_i       (sample_word),
        .sample_valid_i (sample_valid_i),
        .energy_o       (energy),
        .energy_valid_o (energy_valid)
    );

    nid_decision u_decision (
        .clk_i           (clk_i),
        .reset_int_n     (reset_int_n),
        .corr            (corr.decision),
        .energy_i        (energy),
        .energy_valid_i  (energy_valid),
        .mode_i          (mode_i),
        .requested_nid_i (requested_nid_i),
        .nid_o           (nid_o),
        .nid_valid_o     (nid_valid_o)
    );

endmodule

//--- nid_decision.sv
`timescale 1ns/1ns

module nid_decision
    import pss_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 reset_int_n,
    pss_corr_if.decision         corr,
    input  logic [METRIC_DW-1:0] energy_i,
    input  logic                 energy_valid_i,
    input  logic [1:0]           mode_i,
    input  logic [1:0]           requested_nid_i,
    output logic [1:0]           nid_o,
    output logic                 nid_valid_o
);

    logic [METRIC_DW-1:0] metric [3];
    logic [METRIC_DW+2:0] energy_x7;
    logic                 gate;
    logic [2:0]           peak;
    logic                 one_peak;
    logic [1:0]           peak_idx;
    logic                 hit;

    assign metric[0] = corr.metric_0;
    assign metric[1] = corr.metric_1;
    assign metric[2] = corr.metric_2;

    // ----------------------------------------
    // threshold, metric >= 7/8 of energy
    // ----------------------------------------
    assign energy_x7 = {energy_i, 3'b000} - {3'b000, energy_i};
    assign gate      = corr.metric_valid && energy_valid_i && (energy_i >= NOISE_LIMIT);

    always_comb begin
        for (int k = 0; k < 3; k++) begin
            peak[k] = gate && ({metric[k], 3'b000} >= energy_x7);
        end
    end

    // ----------------------------------------
    // mode selection
    // ----------------------------------------
    always_comb begin
        one_peak = 1'b1;
        peak_idx = 2'd0;
        case (peak)
            3'b001: peak_idx = 2'd0;
            3'b010: peak_idx = 2'd1;
            3'b100: peak_idx = 2'd2;
            default: one_peak = 1'b0;
        endcase

        case (mode_i)
            MODE_SEARCH: hit = one_peak;
            // the single peak must be the requested one
            MODE_FIND:   hit = one_peak && (peak_idx == requested_nid_i);
            MODE_PAUSE:  hit = 1'b0;
            default:     hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!reset_int_n) begin
            nid_o       <= 2'd0;
            nid_valid_o <= 1'b0;
        end else begin
            nid_valid_o <= hit;
            if (hit) begin
                nid_o <= peak_idx;
            end
        end
    end

endmodule

//--- window_energy.sv
`timescale 1ns/1ns

module window_energy
    import pss_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 reset_int_n,
    input  sample_t              sample_i,
    input  logic                 sample_valid_i,
    output logic [METRIC_DW-1:0] energy_o,
    output logic                 energy_valid_o
);

    logic signed [IQ_DW:0]          re_ext;
    logic signed [IQ_DW:0]          im_ext;
    logic        [IQ_DW:0]          re_mag;
    logic        [IQ_DW:0]          im_mag;
    logic        [IQ_DW:0]          new_term;
    logic        [IQ_DW:0]          term_hist [PSS_LEN];
    logic        [METRIC_DW-1:0]    run_sum;
    logic        [$clog2(PSS_LEN)-1:0] fill_cnt;
    logic                           full;
    logic                           sum_updated;

    assign re_ext   = sample_i.iq.re;
    assign im_ext   = sample_i.iq.im;
    assign re_mag   = re_ext[IQ_DW] ? -re_ext : re_ext;
    assign im_mag   = im_ext[IQ_DW] ? -im_ext : im_ext;
    assign new_term = re_mag + im_mag;

    // add the new term, drop the one leaving from term_hist[0]
    always_ff @(posedge clk_i) begin
        if (!reset_int_n) begin
            for (int i = 0; i < PSS_LEN; i++) begin
                term_hist[i] <= '0;
            end
            run_sum     <= '0;
            fill_cnt    <= '0;
            full        <= 1'b0;
            sum_updated <= 1'b0;
        end else begin
            sum_updated <= sample_valid_i;
            if (sample_valid_i) begin
                for (int i = 0; i < PSS_LEN - 1; i++) begin
                    term_hist[i] <= term_hist[i + 1];
                end
                term_hist[PSS_LEN - 1] <= new_term;
                run_sum <= run_sum + METRIC_DW'(new_term) - METRIC_DW'(term_hist[0]);
                // warm-up, the window is full after PSS_LEN samples
                if (!full) begin
                    fill_cnt <= fill_cnt + 1'b1;
                    full     <= (fill_cnt == '1);
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_int_n) begin
            energy_valid_o <= 1'b0;
        end else begin
            energy_valid_o <= sum_updated && full;
        end
    end

    always_ff @(posedge clk_i) begin
        energy_o <= run_sum;
    end

endmodule

//--- pss_correlator_bank.sv
`timescale 1ns/1ns

module pss_correlator_bank
    import pss_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_int_n,
    input  sample_t  sample_i,
    input  logic     sample_valid_i,
    pss_corr_if.bank corr
);

    // window[0] holds the oldest sample
    sample_t              window [PSS_LEN];
    logic                 win_updated;
    logic [METRIC_DW-1:0] metric [3];

    // ----------------------------------------
    // sample window
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_int_n) begin
            for (int i = 0; i < PSS_LEN; i++) begin
                window[i] <= '0;
            end
            win_updated <= 1'b0;
        end else begin
            win_updated <= sample_valid_i;
            if (sample_valid_i) begin
                for (int i = 0; i < PSS_LEN - 1; i++) begin
                    window[i] <= window[i + 1];
                end
                window[PSS_LEN - 1] <= sample_i;
            end
        end
    end

    // ----------------------------------------
    // sign-tap correlators
    // ----------------------------------------
    for (genvar k = 0; k < 3; k++) begin : g_corr
        logic signed [METRIC_DW-1:0] re_sum;
        logic signed [METRIC_DW-1:0] im_sum;
        logic        [METRIC_DW-1:0] re_abs;
        logic        [METRIC_DW-1:0] im_abs;

        // taps are +-1, so each product is an add or a subtract
        always_comb begin
            re_sum = '0;
            im_sum = '0;
            for (int i = 0; i < PSS_LEN; i++) begin
                if (PSS_SEQ[k][i]) begin
                    re_sum = re_sum + window[i].iq.re;
                    im_sum = im_sum + window[i].iq.im;
                end else begin
                    re_sum = re_sum - window[i].iq.re;
                    im_sum = im_sum - window[i].iq.im;
                end
            end
        end

        assign re_abs = re_sum[METRIC_DW-1] ? -re_sum : re_sum;
        assign im_abs = im_sum[METRIC_DW-1] ? -im_sum : im_sum;

        // |re| + |im| stands in for the complex magnitude
        assign metric[k] = re_abs + im_abs;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_int_n) begin
            corr.metric_valid <= 1'b0;
        end else begin
            corr.metric_valid <= win_updated;
        end
    end

    always_ff @(posedge clk_i) begin
        corr.metric_0 <= metric[0];
        corr.metric_1 <= metric[1];
        corr.metric_2 <= metric[2];
    end

endmodule

//--- pss_corr_if.sv
`timescale 1ns/1ns

interface pss_corr_if
    import pss_pkg::*;
();

    // one metric per N_id_2, meaningful while metric_valid is high
    logic [METRIC_DW-1:0] metric_0;
    logic [METRIC_DW-1:0] metric_1;
    logic [METRIC_DW-1:0] metric_2;
    logic                 metric_valid;

    modport bank (
        output metric_0,
        output metric_1,
        output metric_2,
        output metric_valid
    );

    modport decision (
        input metric_0,
        input metric_1,
        input metric_2,
        input metric_valid
    );

endinterface

//--- pss_pkg.sv
package pss_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int IQ_DW     = 16;
    localparam int SAMPLE_DW = 2 * IQ_DW;
    localparam int PSS_LEN   = 16;
    localparam int METRIC_DW = 22;

    // ----------------------------------------
    // local sequences
    // ----------------------------------------
    // a one is +1 and a zero is -1, bit 0 meets the oldest sample
    // the outer six taps at both ends are shared by all three, so a partial
    // overlap at the window edges matches all sequences or none
    localparam logic [PSS_LEN-1:0] PSS_SEQ_0 = 16'hAB0B;
    localparam logic [PSS_LEN-1:0] PSS_SEQ_1 = 16'hAA8B;
    localparam logic [PSS_LEN-1:0] PSS_SEQ_2 = 16'hAA4B;

    localparam logic [2:0][PSS_LEN-1:0] PSS_SEQ = {PSS_SEQ_2, PSS_SEQ_1, PSS_SEQ_0};

    // minimum window energy before any peak is accepted
    localparam logic [METRIC_DW-1:0] NOISE_LIMIT = 22'd4096;

    // ----------------------------------------
    // detector modes
    // ----------------------------------------
    localparam logic [1:0] MODE_SEARCH = 2'd0;
    localparam logic [1:0] MODE_FIND   = 2'd1;
    localparam logic [1:0] MODE_PAUSE  = 2'd2;

    // stream word, imag in the upper half
    typedef union packed {
        logic [SAMPLE_DW-1:0] raw;
        struct packed {
            logic signed [IQ_DW-1:0] im;
            logic signed [IQ_DW-1:0] re;
        } iq;
    } sample_t;

endpackage
